// ==== verilog/exec_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared widths and encodings for the execution lane
// flag vector order is N Z C V, top bit down
// opcode and condition encodings are 4 bits and fixed
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package exec_pkg;

  localparam int DATA_W     = 32;
  localparam int REG_COUNT  = 16;
  localparam int REG_ADDR_W = 4;
  localparam int FLAG_W     = 4;
  localparam int SHAMT_W    = 5;  // low bits of operand b

  // bit positions inside the flag vector
  localparam int FLAG_N = 3;
  localparam int FLAG_Z = 2;
  localparam int FLAG_C = 1;
  localparam int FLAG_V = 0;

  typedef enum logic [3:0] {
    op_add   = 4'd0,
    op_sub   = 4'd1,
    op_and   = 4'd2,
    op_or    = 4'd3,
    op_xor   = 4'd4,
    op_shl   = 4'd5,
    op_shr   = 4'd6,
    op_sar   = 4'd7,
    op_sxb   = 4'd8,
    op_sxh   = 4'd9,
    op_bswap = 4'd10,
    op_movi  = 4'd11  // 12..15 unused
  } opcode_t;

  typedef enum logic [3:0] {
    cc_eq = 4'd0,
    cc_ne = 4'd1,
    cc_cs = 4'd2,
    cc_cc = 4'd3,
    cc_mi = 4'd4,
    cc_pl = 4'd5,
    cc_vs = 4'd6,
    cc_vc = 4'd7,
    cc_hi = 4'd8,
    cc_ls = 4'd9,
    cc_ge = 4'd10,
    cc_lt = 4'd11,
    cc_gt = 4'd12,
    cc_le = 4'd13,
    cc_al = 4'd14,
    cc_nv = 4'd15
  } cond_t;

endpackage

`default_nettype wire

// ==== verilog/reg_file.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 16 x 32 register file
// two combinational reads, one write per clock
// no internal bypass; a read in the write cycle sees the old word
// reset clears every register
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module reg_file import exec_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [REG_ADDR_W-1:0] rd_addr_a,
  input  logic [REG_ADDR_W-1:0] rd_addr_b,
  output logic [DATA_W-1:0]     rd_data_a,
  output logic [DATA_W-1:0]     rd_data_b,
  input  logic                  wr_en,
  input  logic [REG_ADDR_W-1:0] wr_addr,
  input  logic [DATA_W-1:0]     wr_data
);

  logic [DATA_W-1:0] regs [REG_COUNT];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_addr] <= wr_data;
    end
  end

  assign rd_data_a = regs[rd_addr_a];
  assign rd_data_b = regs[rd_addr_b];

endmodule

`default_nettype wire

// ==== verilog/operand_stage.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// operand read and issue register
// forwards the value being written this cycle over register file data
// immediate replaces operand b when issue_use_imm is set
// one cycle from issue edge to ex_ outputs
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module operand_stage import exec_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  issue_valid,
  input  opcode_t               issue_op,
  input  cond_t                 issue_cond,
  input  logic [REG_ADDR_W-1:0] issue_rd,
  input  logic [REG_ADDR_W-1:0] issue_ra,
  input  logic [REG_ADDR_W-1:0] issue_rb,
  input  logic [DATA_W-1:0]     issue_imm,
  input  logic                  issue_use_imm,
  output logic [REG_ADDR_W-1:0] rd_addr_a,
  output logic [REG_ADDR_W-1:0] rd_addr_b,
  input  logic [DATA_W-1:0]     rd_data_a,
  input  logic [DATA_W-1:0]     rd_data_b,
  input  logic                  fwd_en,
  input  logic [REG_ADDR_W-1:0] fwd_addr,
  input  logic [DATA_W-1:0]     fwd_data,
  output logic                  ex_valid,
  output opcode_t               ex_op,
  output cond_t                 ex_cond,
  output logic [REG_ADDR_W-1:0] ex_rd,
  output logic [DATA_W-1:0]     ex_a,
  output logic [DATA_W-1:0]     ex_b
);

  logic [DATA_W-1:0] a_val;
  logic [DATA_W-1:0] b_reg_val;
  logic [DATA_W-1:0] b_val;

  assign rd_addr_a = issue_ra;
  assign rd_addr_b = issue_rb;

  // bypass the write in flight
  assign a_val     = (fwd_en && fwd_addr == issue_ra) ? fwd_data : rd_data_a;
  assign b_reg_val = (fwd_en && fwd_addr == issue_rb) ? fwd_data : rd_data_b;
  assign b_val     = issue_use_imm ? issue_imm : b_reg_val;

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid <= 1'b0;
    end else begin
      ex_valid <= issue_valid;
    end
  end

  // payload, qualified by ex_valid downstream
  always_ff @(posedge clk) begin
    ex_op   <= issue_op;
    ex_cond <= issue_cond;
    ex_rd   <= issue_rd;
    ex_a    <= a_val;
    ex_b    <= b_val;
  end

endmodule

`default_nettype wire

// ==== verilog/alu.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// integer ALU, purely combinational
// shifts take the low 5 bits of b
// only add and sub produce C and V; other ops clear them
// sub carry is set when no borrow occurs
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module alu import exec_pkg::*; (
  input  opcode_t             op,
  input  logic [DATA_W-1:0]   a,
  input  logic [DATA_W-1:0]   b,
  output logic [DATA_W-1:0]   result,
  output logic [FLAG_W-1:0]   flags
);

  logic [SHAMT_W-1:0] shamt;
  logic [DATA_W:0]    sum;
  logic [DATA_W:0]    diff;
  logic               add_ovf;
  logic               sub_ovf;
  logic               carry;
  logic               ovf;

  assign shamt = b[SHAMT_W-1:0];

  // one extra bit for carry out
  assign sum  = {1'b0, a} + {1'b0, b};
  assign diff = {1'b0, a} + {1'b0, ~b} + {{DATA_W{1'b0}}, 1'b1};

  // signed overflow
  assign add_ovf = (a[DATA_W-1] == b[DATA_W-1]) && (sum[DATA_W-1] != a[DATA_W-1]);
  assign sub_ovf = (a[DATA_W-1] != b[DATA_W-1]) && (diff[DATA_W-1] != a[DATA_W-1]);

  always_comb begin
    result = '0;
    carry  = 1'b0;
    ovf    = 1'b0;
    case (op)
      op_add: begin
        result = sum[DATA_W-1:0];
        carry  = sum[DATA_W];
        ovf    = add_ovf;
      end
      op_sub: begin
        result = diff[DATA_W-1:0];
        carry  = diff[DATA_W];
        ovf    = sub_ovf;
      end
      op_and:   result = a & b;
      op_or:    result = a | b;
      op_xor:   result = a ^ b;
      op_shl:   result = a << shamt;
      op_shr:   result = a >> shamt;
      op_sar:   result = $signed(a) >>> shamt;
      op_sxb:   result = {{(DATA_W-8){a[7]}}, a[7:0]};
      op_sxh:   result = {{(DATA_W-16){a[15]}}, a[15:0]};
      op_bswap: result = {a[7:0], a[15:8], a[23:16], a[31:24]};
      op_movi:  result = b;  // immediate pass
      default:  result = '0;
    endcase
  end

  always_comb begin
    flags         = '0;
    flags[FLAG_N] = result[DATA_W-1];
    flags[FLAG_Z] = (result == '0);
    flags[FLAG_C] = carry;
    flags[FLAG_V] = ovf;
  end

endmodule

`default_nettype wire

// ==== verilog/exec_stage.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// condition test, flags register and writeback register
// cond is checked against flags left by the previous instruction
// failed cond still pulses wb_valid with wb_we low
// register write and flags update share the edge raising wb_valid
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module exec_stage import exec_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  ex_valid,
  input  cond_t                 ex_cond,
  input  logic [REG_ADDR_W-1:0] ex_rd,
  input  logic [DATA_W-1:0]     alu_result,
  input  logic [FLAG_W-1:0]     alu_flags,
  output logic                  wr_en,
  output logic [REG_ADDR_W-1:0] wr_addr,
  output logic [DATA_W-1:0]     wr_data,
  output logic                  wb_valid,
  output logic                  wb_we,
  output logic [REG_ADDR_W-1:0] wb_rd,
  output logic [DATA_W-1:0]     wb_data,
  output logic [FLAG_W-1:0]     wb_flags
);

  logic [FLAG_W-1:0] flags_q;
  logic              pass;

  function automatic logic cond_eval(input cond_t cond, input logic [FLAG_W-1:0] fl);
    logic n;
    logic z;
    logic c;
    logic v;
    n = fl[FLAG_N];
    z = fl[FLAG_Z];
    c = fl[FLAG_C];
    v = fl[FLAG_V];
    case (cond)
      cc_eq:   return z;
      cc_ne:   return !z;
      cc_cs:   return c;
      cc_cc:   return !c;
      cc_mi:   return n;
      cc_pl:   return !n;
      cc_vs:   return v;
      cc_vc:   return !v;
      cc_hi:   return c && !z;
      cc_ls:   return !c || z;
      cc_ge:   return n == v;
      cc_lt:   return n != v;
      cc_gt:   return !z && (n == v);
      cc_le:   return z || (n != v);
      cc_al:   return 1'b1;
      default: return 1'b0;  // cc_nv
    endcase
  endfunction

  assign pass = cond_eval(ex_cond, flags_q);

  // write port, also the forwarding source
  assign wr_en   = ex_valid && pass;
  assign wr_addr = ex_rd;
  assign wr_data = alu_result;

  always_ff @(posedge clk) begin
    if (rst) begin
      flags_q  <= '0;
      wb_valid <= 1'b0;
      wb_we    <= 1'b0;
    end else begin
      wb_valid <= ex_valid;
      wb_we    <= wr_en;
      if (wr_en) flags_q <= alu_flags;
    end
  end

  always_ff @(posedge clk) begin
    wb_rd    <= ex_rd;
    wb_data  <= alu_result;
    wb_flags <= alu_flags;  // shown even when not written
  end

endmodule

`default_nettype wire

// ==== verilog/exec_core.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execution lane top level
// fixed two cycle latency, no back-pressure
// every issue_valid gives exactly one wb_valid pulse
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module exec_core import exec_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  issue_valid,
  input  opcode_t               issue_op,
  input  cond_t                 issue_cond,
  input  logic [REG_ADDR_W-1:0] issue_rd,
  input  logic [REG_ADDR_W-1:0] issue_ra,
  input  logic [REG_ADDR_W-1:0] issue_rb,
  input  logic [DATA_W-1:0]     issue_imm,
  input  logic                  issue_use_imm,
  output logic                  wb_valid,
  output logic                  wb_we,
  output logic [REG_ADDR_W-1:0] wb_rd,
  output logic [DATA_W-1:0]     wb_data,
  output logic [FLAG_W-1:0]     wb_flags
);

  logic [REG_ADDR_W-1:0] rd_addr_a;
  logic [REG_ADDR_W-1:0] rd_addr_b;
  logic [DATA_W-1:0]     rd_data_a;
  logic [DATA_W-1:0]     rd_data_b;
  logic                  wr_en;
  logic [REG_ADDR_W-1:0] wr_addr;
  logic [DATA_W-1:0]     wr_data;
  logic                  ex_valid;
  opcode_t               ex_op;
  cond_t                 ex_cond;
  logic [REG_ADDR_W-1:0] ex_rd;
  logic [DATA_W-1:0]     ex_a;
  logic [DATA_W-1:0]     ex_b;
  logic [DATA_W-1:0]     alu_result;
  logic [FLAG_W-1:0]     alu_flags;

  reg_file u_reg_file (
    .clk       (clk),
    .rst       (rst),
    .rd_addr_a (rd_addr_a),
    .rd_addr_b (rd_addr_b),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data)
  );

  operand_stage u_operand_stage (
    .clk           (clk),
    .rst           (rst),
    .issue_valid   (issue_valid),
    .issue_op      (issue_op),
    .issue_cond    (issue_cond),
    .issue_rd      (issue_rd),
    .issue_ra      (issue_ra),
    .issue_rb      (issue_rb),
    .issue_imm     (issue_imm),
    .issue_use_imm (issue_use_imm),
    .rd_addr_a     (rd_addr_a),
    .rd_addr_b     (rd_addr_b),
    .rd_data_a     (rd_data_a),
    .rd_data_b     (rd_data_b),
    .fwd_en        (wr_en),  // forward from the write port
    .fwd_addr      (wr_addr),
    .fwd_data      (wr_data),
    .ex_valid      (ex_valid),
    .ex_op         (ex_op),
    .ex_cond       (ex_cond),
    .ex_rd         (ex_rd),
    .ex_a          (ex_a),
    .ex_b          (ex_b)
  );

  alu u_alu (
    .op     (ex_op),
    .a      (ex_a),
    .b      (ex_b),
    .result (alu_result),
    .flags  (alu_flags)
  );

  exec_stage u_exec_stage (
    .clk        (clk),
    .rst        (rst),
    .ex_valid   (ex_valid),
    .ex_cond    (ex_cond),
    .ex_rd      (ex_rd),
    .alu_result (alu_result),
    .alu_flags  (alu_flags),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .wb_valid   (wb_valid),
    .wb_we      (wb_we),
    .wb_rd      (wb_rd),
    .wb_data    (wb_data),
    .wb_flags   (wb_flags)
  );

endmodule

`default_nettype wire

// ==== sim/exec_core_assert.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// timing checks bound to exec_core
// assumes the fixed two cycle lane latency
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module exec_core_assert (
  input logic clk,
  input logic rst,
  input logic issue_valid,
  input logic wb_valid,
  input logic wb_we
);
  timeunit 1ns;
  timeprecision 1ps;

  a_latency: assert property (@(posedge clk) disable iff (rst)
    issue_valid |-> ##2 wb_valid)
    else $error("wb_valid did not follow issue_valid after 2 cycles");

  a_no_extra: assert property (@(posedge clk) disable iff (rst)
    wb_valid |-> $past(issue_valid, 2))
    else $error("wb_valid without an issue 2 cycles earlier");

  // low during reset and the cycle after
  a_reset: assert property (@(posedge clk)
    ($past(rst) || $past(rst, 2)) |-> (!wb_valid && !wb_we))
    else $error("writeback active around reset");

  a_we_valid: assert property (@(posedge clk) wb_we |-> wb_valid)
    else $error("wb_we high without wb_valid");

endmodule

bind exec_core exec_core_assert u_exec_core_assert (
  .clk         (clk),
  .rst         (rst),
  .issue_valid (issue_valid),
  .wb_valid    (wb_valid),
  .wb_we       (wb_we)
);

`default_nettype wire

// ==== sim/exec_core_tb.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the execution lane
// replays sim/exec_testdata.txt, then a seeded random stream
// writebacks are sampled on the falling edge, two cycles after issue
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module exec_core_tb import exec_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  logic clk;
  logic rst;
  logic issue_valid;
  opcode_t issue_op;
  cond_t issue_cond;
  logic [REG_ADDR_W-1:0] issue_rd;
  logic [REG_ADDR_W-1:0] issue_ra;
  logic [REG_ADDR_W-1:0] issue_rb;
  logic [DATA_W-1:0] issue_imm;
  logic issue_use_imm;
  logic wb_valid;
  logic wb_we;
  logic [REG_ADDR_W-1:0] wb_rd;
  logic [DATA_W-1:0] wb_data;
  logic [FLAG_W-1:0] wb_flags;

  // expected writebacks in issue order
  int q_cyc[$];
  string q_name[$];
  bit q_report[$];
  logic q_we[$];
  logic [3:0] q_rd[$];
  logic [31:0] q_data[$];
  logic [3:0] q_flags[$];

  logic [31:0] mregs[16];  // reference register file
  logic [3:0] mflags;
  int cyc;
  int issue_cyc;
  int errors;
  int err_before;
  int tests_run;
  int tests_failed;
  int seed;
  int fd;
  int cnt;
  int line_no;
  int rand_err;
  string line;
  string nm;
  logic [31:0] f_op;
  logic [31:0] f_cond;
  logic [31:0] f_rd;
  logic [31:0] f_ra;
  logic [31:0] f_rb;
  logic [31:0] f_imm;
  logic [31:0] f_use;
  logic [31:0] f_we;
  logic [31:0] f_data;
  logic [31:0] f_flags;
  int r_op;
  int r_cond;
  int r_rd;
  int r_ra;
  int r_rb;
  logic [31:0] r_imm;
  bit r_use;
  bit ok;
  logic [31:0] ma;
  logic [31:0] mb;
  logic [35:0] pr;

  exec_core UUT (
    .clk           (clk),
    .rst           (rst),
    .issue_valid   (issue_valid),
    .issue_op      (issue_op),
    .issue_cond    (issue_cond),
    .issue_rd      (issue_rd),
    .issue_ra      (issue_ra),
    .issue_rb      (issue_rb),
    .issue_imm     (issue_imm),
    .issue_use_imm (issue_use_imm),
    .wb_valid      (wb_valid),
    .wb_we         (wb_we),
    .wb_rd         (wb_rd),
    .wb_data       (wb_data),
    .wb_flags      (wb_flags)
  );

  always #50 clk = ~clk;

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  // flags N Z C V from the result and the add/sub carry rules
  function automatic logic [35:0] predict_alu(input int op, input logic [31:0] a,
                                              input logic [31:0] b);
    logic [31:0] r;
    logic c;
    logic v;
    longint s;
    c = 1'b0;
    v = 1'b0;
    case (op)
      0: begin
        r = a + b;
        c = ({1'b0, a} + {1'b0, b}) > 33'h0ffffffff;
        s = longint'($signed(a)) + longint'($signed(b));
        v = s != longint'($signed(r));  // true sum does not fit
      end
      1: begin
        r = a - b;
        c = (a >= b);  // no borrow
        s = longint'($signed(a)) - longint'($signed(b));
        v = s != longint'($signed(r));
      end
      2: r = a & b;
      3: r = a | b;
      4: r = a ^ b;
      5: r = a << b[4:0];
      6: r = a >> b[4:0];
      7: r = $unsigned($signed(a) >>> b[4:0]);
      8: r = 32'($signed(a[7:0]));
      9: r = 32'($signed(a[15:0]));
      10: begin
        for (int i = 0; i < 4; i++) begin
          r[8*i +: 8] = a[8*(3-i) +: 8];
        end
      end
      default: r = b;
    endcase
    return {r[31], r == 32'd0, c, v, r};
  endfunction

  function automatic bit cond_holds(input int cond, input logic [3:0] fl);
    case (cond)
      0: return fl[2];
      1: return !fl[2];
      2: return fl[1];
      3: return !fl[1];
      4: return fl[3];
      5: return !fl[3];
      6: return fl[0];
      7: return !fl[0];
      8: return fl[1] && !fl[2];
      9: return !fl[1] || fl[2];
      10: return fl[3] == fl[0];
      11: return fl[3] != fl[0];
      12: return !fl[2] && (fl[3] == fl[0]);
      13: return fl[2] || (fl[3] != fl[0]);
      14: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  task automatic issue(input int op, input int cond, input int rd, input int ra,
                       input int rb, input logic [31:0] imm, input bit use_imm);
    @(posedge clk);
    issue_valid   <= 1'b1;
    issue_op      <= opcode_t'(op[3:0]);
    issue_cond    <= cond_t'(cond[3:0]);
    issue_rd      <= rd[3:0];
    issue_ra      <= ra[3:0];
    issue_rb      <= rb[3:0];
    issue_imm     <= imm;
    issue_use_imm <= use_imm;
    issue_cyc = cyc;
  endtask

  task automatic expect_wb(input string name, input bit report, input logic we,
                           input int rd, input logic [31:0] data, input logic [3:0] fl);
    q_cyc.push_back(issue_cyc + 2);
    q_name.push_back(name);
    q_report.push_back(report);
    q_we.push_back(we);
    q_rd.push_back(rd[3:0]);
    q_data.push_back(data);
    q_flags.push_back(fl);
  endtask

  task automatic pop_expected();
    void'(q_cyc.pop_front());
    void'(q_name.pop_front());
    void'(q_report.pop_front());
    void'(q_we.pop_front());
    void'(q_rd.pop_front());
    void'(q_data.pop_front());
    void'(q_flags.pop_front());
  endtask

  // writeback monitor samples on the falling edge
  always @(negedge clk) begin
    if (!rst) begin
      if (wb_valid) begin
        if (q_cyc.size() == 0) begin
          $display("unexpected writeback pulse with nothing issued");
          errors++;
        end else begin
          err_before = errors;
          nm = q_name[0];
          if (cyc != q_cyc[0]) begin
            $display("writeback for %s arrived at cycle %0d, not %0d", nm, cyc, q_cyc[0]);
            errors++;
          end
          check_val({nm, " we"}, 32'(q_we[0]), 32'(wb_we));
          check_val({nm, " rd"}, 32'(q_rd[0]), 32'(wb_rd));
          check_val({nm, " data"}, q_data[0], wb_data);
          check_val({nm, " flags"}, 32'(q_flags[0]), 32'(wb_flags));
          if (q_report[0]) begin
            tests_run++;
            if (errors != err_before) tests_failed++;
            $display("test %s: %s", nm, (errors == err_before) ? "ok" : "failed");
          end
          pop_expected();
        end
      end else if (q_cyc.size() > 0 && cyc > q_cyc[0]) begin
        $display("no writeback pulse for %s", q_name[0]);
        errors++;
        if (q_report[0]) begin
          tests_run++;
          tests_failed++;
          $display("test %s: failed", q_name[0]);
        end
        pop_expected();
      end
    end
    cyc++;
  end

  initial begin
    #1000000;
    $display("simulation watchdog expired");
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    issue_valid = 1'b0;
    issue_op = op_add;
    issue_cond = cc_al;
    issue_rd = '0;
    issue_ra = '0;
    issue_rb = '0;
    issue_imm = '0;
    issue_use_imm = 1'b0;
    cyc = 0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    line_no = 0;
    seed = 32'h40c8;
    mflags = 4'h0;
    for (int i = 0; i < 16; i++) mregs[i] = 32'd0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    fd = $fopen("sim/exec_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open the testdata file");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        cnt = $fgets(line, fd);
        if (cnt > 0 && line.getc(0) != 8'h23) begin
          cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", f_op, f_cond, f_rd, f_ra,
                        f_rb, f_imm, f_use, f_we, f_data, f_flags);
          if (cnt == 10) begin
            line_no++;
            issue(int'(f_op), int'(f_cond), int'(f_rd), int'(f_ra), int'(f_rb), f_imm,
                  f_use[0]);
            expect_wb($sformatf("line_%0d", line_no), 1'b1, f_we[0], int'(f_rd), f_data,
                      f_flags[3:0]);
            if (f_we[0]) begin
              mregs[f_rd[3:0]] = f_data;
              mflags = f_flags[3:0];
            end
          end
        end
      end
      $fclose(fd);
    end

    // random back-to-back stream against the model
    rand_err = errors;
    for (int n = 0; n < 200; n++) begin
      r_op = int'($unsigned($random(seed)) % 12);
      r_cond = ($random(seed) & 1) ? 14 : int'($unsigned($random(seed)) % 16);
      r_rd = int'($unsigned($random(seed)) % 16);
      r_ra = int'($unsigned($random(seed)) % 16);
      r_rb = int'($unsigned($random(seed)) % 16);
      r_imm = $random(seed);
      r_use = ($random(seed) & 1) != 0;
      ma = mregs[r_ra];
      mb = r_use ? r_imm : mregs[r_rb];
      pr = predict_alu(r_op, ma, mb);
      ok = cond_holds(r_cond, mflags);
      issue(r_op, r_cond, r_rd, r_ra, r_rb, r_imm, r_use);
      expect_wb($sformatf("rand_%0d", n), 1'b0, ok, r_rd, pr[31:0], pr[35:32]);
      if (ok) begin
        mregs[r_rd] = pr[31:0];
        mflags = pr[35:32];
      end
    end
    @(posedge clk);
    issue_valid <= 1'b0;

    for (int t = 0; t < 20 && q_cyc.size() > 0; t++) @(posedge clk);
    if (q_cyc.size() > 0) begin
      $display("timed out waiting for %0d writebacks", q_cyc.size());
      errors++;
    end
    tests_run++;
    if (errors != rand_err) tests_failed++;
    $display("test random: %s", (errors == rand_err) ? "ok" : "failed");

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/exec_testdata.txt ====
# columns: op cond rd ra rb imm use_imm | expected we data flags (all hex)
# flags are N Z C V from bit 3 down
b e 1 0 0 7fffffff 1 1 7fffffff 0
b e 2 0 0 00000001 1 1 00000001 0
0 e 3 1 2 00000000 0 1 80000000 9
1 e 4 3 2 00000000 0 1 7fffffff 3
b e 5 0 0 ffffffff 1 1 ffffffff 8
0 e 6 5 2 00000000 0 1 00000000 6
1 e 7 2 5 00000000 0 1 00000002 0
1 e 8 2 2 00000000 0 1 00000000 6
b 0 9 0 0 00000011 1 1 00000011 0
b 0 a 0 0 00000022 1 0 00000022 0
b 1 a 0 0 00000033 1 1 00000033 0
0 e b 5 5 00000000 0 1 fffffffe a
b 8 c 0 0 00000044 1 1 00000044 0
b 2 c 0 0 00000066 1 0 00000066 0
3 e d c 9 00000000 0 1 00000055 0
5 e e 2 0 00000004 1 1 00000010 0
7 e f 3 0 00000004 1 1 f8000000 8
6 e f f 0 00000004 1 1 0f800000 0
8 e 6 b 0 00000000 0 1 fffffffe 8
9 e 7 1 0 00000000 0 1 ffffffff 8
a e 8 e 0 00000000 0 1 10000000 0
4 e 9 5 1 00000000 0 1 80000000 8
2 e a 5 0 00000000 1 1 00000000 4
b f a 0 0 00000077 1 0 00000077 0
0 e 4 a 4 00000000 0 1 7fffffff 0

// ==== exec_core.f ====
verilog/exec_pkg.sv
verilog/reg_file.sv
verilog/operand_stage.sv
verilog/alu.sv
verilog/exec_stage.sv
verilog/exec_core.sv
sim/exec_core_assert.sv
sim/exec_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the execution lane testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module exec_core_tb \
  -f exec_core.f -o exec_core_sim \
  && ./obj_dir/exec_core_sim 2>&1 | tee sim.log \
  || { echo "build or simulation failed"; exit 1; }

! grep -q ">>> FAIL" sim.log && grep -q ">>> PASS" sim.log || exit 1
